// ==== src/operand_fetch_pkg.sv ====
package operand_fetch_pkg;

	localparam int n_channels = 16;

	typedef logic [3:0] chan_idx_t;
	typedef logic [4:0] opcode_t;
	typedef logic [3:0] pending_cnt_t;
	typedef logic [3:0] src_code_t;

	// Immediate source codes. Any other code reads as zero.
	localparam src_code_t src_reg_0 = 4'd0;
	localparam src_code_t src_reg_1 = 4'd1;
	localparam src_code_t src_half = 4'd3;
	localparam src_code_t src_top = 4'd4;

	// Source field of one operand.
	// Channel index or immediate code, picked by the operand's immediate flag.
	typedef union packed {
		chan_idx_t chan;
		src_code_t code;
	} src_sel_u;

endpackage

// ==== src/channel_file.sv ====
module channel_file #(
	parameter int data_width = 16
) (
	input logic clk,
	input logic reset,
	input logic channel_write_enable,
	input operand_fetch_pkg::chan_idx_t channel_write_addr,
	input logic [data_width - 1:0] channel_write_val,
	input operand_fetch_pkg::chan_idx_t read_addr_a,
	input operand_fetch_pkg::chan_idx_t read_addr_b,
	input operand_fetch_pkg::chan_idx_t read_addr_c,
	output logic [data_width - 1:0] read_val_a,
	output logic [data_width - 1:0] read_val_b,
	output logic [data_width - 1:0] read_val_c
);
	logic [data_width - 1:0] channels [operand_fetch_pkg::n_channels];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < operand_fetch_pkg::n_channels; i++) begin
				channels[i] <= '0;
			end
		end else if (channel_write_enable) begin
			channels[channel_write_addr] <= channel_write_val;
		end
	end

	// One asynchronous read port per substage.
	assign read_val_a = channels[read_addr_a];
	assign read_val_b = channels[read_addr_b];
	assign read_val_c = channels[read_addr_c];

endmodule

// ==== src/pending_write_counter.sv ====
module pending_write_counter (
	input logic clk,
	input logic reset,
	input logic issue_write,
	input operand_fetch_pkg::chan_idx_t issue_dest,
	input logic channel_write_enable,
	input operand_fetch_pkg::chan_idx_t channel_write_addr,
	input operand_fetch_pkg::chan_idx_t query_idx,
	output operand_fetch_pkg::pending_cnt_t query_pending,
	output logic query_busy
);
	operand_fetch_pkg::pending_cnt_t counts [operand_fetch_pkg::n_channels];
	logic [operand_fetch_pkg::n_channels - 1:0] busy;
	logic [operand_fetch_pkg::n_channels - 1:0] inc_hit;
	logic [operand_fetch_pkg::n_channels - 1:0] dec_hit;

	always_comb begin
		inc_hit = '0;
		dec_hit = '0;
		inc_hit[issue_dest] = issue_write;
		dec_hit[channel_write_addr] = channel_write_enable;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= '0;
			for (int i = 0; i < operand_fetch_pkg::n_channels; i++) begin
				counts[i] <= '0;
			end
		end else begin
			for (int i = 0; i < operand_fetch_pkg::n_channels; i++) begin
				case ({inc_hit[i], dec_hit[i]})
					2'b10: begin
						counts[i] <= counts[i] + 1'b1;
						busy[i] <= 1'b1;
					end
					2'b01: begin
						// Never drops below zero.
						if (counts[i] != '0) begin
							counts[i] <= counts[i] - 1'b1;
						end
						busy[i] <= counts[i] > 4'd1;
					end
					default: busy[i] <= counts[i] != '0;
				endcase
			end
		end
	end

	assign query_pending = counts[query_idx];
	assign query_busy = busy[query_idx];

endmodule

// ==== src/fetch_control.sv ====
module fetch_control (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic out_ready,
	input logic needs_hold,
	input logic resolved,
	output logic in_ready,
	output logic out_valid,
	output logic load_direct,
	output logic load_held,
	output logic capture,
	output logic holding
);
	localparam logic st_idle = 1'b0;
	localparam logic st_holding = 1'b1;

	logic state;
	logic out_free;
	logic take;

	// Output register is empty or drains this cycle.
	assign out_free = !out_valid || out_ready;

	assign holding = state == st_holding;
	assign in_ready = !holding && out_free;
	assign take = in_valid && in_ready;

	assign load_direct = take && !needs_hold;
	assign capture = take && needs_hold;
	assign load_held = holding && resolved && out_free;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (capture) begin
						state <= st_holding;
					end
				end
				default: begin
					if (load_held) begin
						state <= st_idle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (load_direct || load_held) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

endmodule

// ==== src/operand_select.sv ====
module operand_select #(
	parameter int data_width = 16
) (
	input logic clk,
	input logic reset,
	input logic capture,
	input logic holding,
	input operand_fetch_pkg::src_sel_u src,
	input logic src_imm,
	input logic needed,
	input logic [data_width - 1:0] register_0,
	input logic [data_width - 1:0] register_1,
	input logic [data_width - 1:0] read_val,
	input operand_fetch_pkg::pending_cnt_t pending,
	input logic channel_write_enable,
	input operand_fetch_pkg::chan_idx_t channel_write_addr,
	input logic [data_width - 1:0] channel_write_val,
	output logic [data_width - 1:0] direct_val,
	output logic [data_width - 1:0] held_val,
	output logic resolved
);
	operand_fetch_pkg::chan_idx_t held_chan;
	logic [data_width - 1:0] imm_val;
	logic [data_width - 1:0] live_val;
	logic [data_width - 1:0] stored_val;
	logic stored;
	logic from_read;
	logic from_forward;

	always_comb begin
		imm_val = '0;
		case (src.code)
			operand_fetch_pkg::src_reg_0: imm_val = register_0;
			operand_fetch_pkg::src_reg_1: imm_val = register_1;
			operand_fetch_pkg::src_half: imm_val[data_width - 2] = 1'b1;
			operand_fetch_pkg::src_top: imm_val[data_width - 1] = 1'b1;
			default: imm_val = '0;
		endcase
	end

	assign direct_val = !needed ? '0 : (src_imm ? imm_val : read_val);

	// Last pending write lands this cycle, so take it off the writeback port.
	assign from_read = pending == '0;
	assign from_forward = pending == 4'd1 && channel_write_enable
		&& channel_write_addr == held_chan;

	assign live_val = from_read ? read_val : channel_write_val;
	assign held_val = stored ? stored_val : live_val;
	assign resolved = holding && (stored || from_read || from_forward);

	always_ff @(posedge clk) begin
		if (reset || capture) begin
			stored <= 1'b0;
		end else if (holding && (from_read || from_forward)) begin
			stored <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			held_chan <= src.chan;
		end
		if (holding && !stored && (from_read || from_forward)) begin
			stored_val <= live_val;
		end
	end

endmodule

// ==== src/fetch_substage.sv ====
module fetch_substage #(
	parameter int data_width = 16,
	parameter int slot = 0
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic out_ready,
	input operand_fetch_pkg::opcode_t opcode_in,
	input operand_fetch_pkg::chan_idx_t dest_in,
	input logic writes_channel_in,
	input logic [data_width - 1:0] register_0_in, register_1_in,
	input operand_fetch_pkg::src_sel_u src_a_in, src_b_in, src_c_in,
	input logic src_a_imm_in, src_b_imm_in, src_c_imm_in,
	input logic arg_a_needed_in, arg_b_needed_in, arg_c_needed_in,
	input logic [data_width - 1:0] arg_a_in, arg_b_in, arg_c_in,
	input logic [data_width - 1:0] read_val,
	input logic channel_write_enable,
	input operand_fetch_pkg::chan_idx_t channel_write_addr,
	input logic [data_width - 1:0] channel_write_val,
	output logic in_ready,
	output logic out_valid,
	output operand_fetch_pkg::chan_idx_t read_addr,
	output operand_fetch_pkg::opcode_t opcode_out,
	output operand_fetch_pkg::chan_idx_t dest_out,
	output logic writes_channel_out,
	output logic [data_width - 1:0] register_0_out, register_1_out,
	output operand_fetch_pkg::src_sel_u src_a_out, src_b_out, src_c_out,
	output logic src_a_imm_out, src_b_imm_out, src_c_imm_out,
	output logic arg_a_needed_out, arg_b_needed_out, arg_c_needed_out,
	output logic [data_width - 1:0] arg_a_out, arg_b_out, arg_c_out
);
	operand_fetch_pkg::src_sel_u [2:0] src_live, src_held, src_cur;
	logic [2:0] imm_live, imm_held, imm_cur;
	logic [2:0] needed_live, needed_held, needed_cur;
	logic [2:0][data_width - 1:0] arg_live, arg_held, arg_cur, arg_q;
	operand_fetch_pkg::opcode_t opcode_held;
	operand_fetch_pkg::chan_idx_t dest_held, dest_cur;
	logic writes_channel_held, writes_channel_cur;
	logic [data_width - 1:0] register_0_held, register_1_held;
	logic [data_width - 1:0] direct_val, held_val;
	operand_fetch_pkg::pending_cnt_t pending;
	logic busy, resolved, needs_hold;
	logic holding, capture, load_direct, load_held, send;

	assign src_live = {src_c_in, src_b_in, src_a_in};
	assign imm_live = {src_c_imm_in, src_b_imm_in, src_a_imm_in};
	assign needed_live = {arg_c_needed_in, arg_b_needed_in, arg_a_needed_in};
	assign arg_live = {arg_c_in, arg_b_in, arg_a_in};

	// While holding, the captured instruction stands in for the input.
	assign src_cur = holding ? src_held : src_live;
	assign imm_cur = holding ? imm_held : imm_live;
	assign needed_cur = holding ? needed_held : needed_live;
	assign arg_cur = holding ? arg_held : arg_live;
	assign dest_cur = holding ? dest_held : dest_in;
	assign writes_channel_cur = holding ? writes_channel_held : writes_channel_in;

	assign read_addr = src_cur[slot].chan;
	assign needs_hold = needed_live[slot] && !imm_live[slot] && busy;
	assign send = load_direct || load_held;

	fetch_control control (
		.clk(clk), .reset(reset), .in_valid(in_valid), .out_ready(out_ready),
		.needs_hold(needs_hold), .resolved(resolved), .in_ready(in_ready),
		.out_valid(out_valid), .load_direct(load_direct), .load_held(load_held),
		.capture(capture), .holding(holding)
	);

	pending_write_counter counter (
		.clk(clk), .reset(reset), .issue_write(send && writes_channel_cur),
		.issue_dest(dest_cur), .channel_write_enable(channel_write_enable),
		.channel_write_addr(channel_write_addr), .query_idx(read_addr),
		.query_pending(pending), .query_busy(busy)
	);

	operand_select #(.data_width(data_width)) select (
		.clk(clk), .reset(reset), .capture(capture), .holding(holding),
		.src(src_live[slot]), .src_imm(imm_live[slot]), .needed(needed_live[slot]),
		.register_0(register_0_in), .register_1(register_1_in), .read_val(read_val),
		.pending(pending), .channel_write_enable(channel_write_enable),
		.channel_write_addr(channel_write_addr), .channel_write_val(channel_write_val),
		.direct_val(direct_val), .held_val(held_val), .resolved(resolved)
	);

	always_ff @(posedge clk) begin
		if (capture) begin
			opcode_held <= opcode_in;
			dest_held <= dest_in;
			writes_channel_held <= writes_channel_in;
			register_0_held <= register_0_in;
			register_1_held <= register_1_in;
			src_held <= src_live;
			imm_held <= imm_live;
			needed_held <= needed_live;
			arg_held <= arg_live;
		end
	end

	always_ff @(posedge clk) begin
		if (send) begin
			opcode_out <= holding ? opcode_held : opcode_in;
			dest_out <= dest_cur;
			writes_channel_out <= writes_channel_cur;
			register_0_out <= holding ? register_0_held : register_0_in;
			register_1_out <= holding ? register_1_held : register_1_in;
			{src_c_out, src_b_out, src_a_out} <= src_cur;
			{src_c_imm_out, src_b_imm_out, src_a_imm_out} <= imm_cur;
			{arg_c_needed_out, arg_b_needed_out, arg_a_needed_out} <= needed_cur;
			// Own operand gets the fetched value, the others pass through.
			for (int i = 0; i < 3; i++) begin
				arg_q[i] <= (i == slot) ? (holding ? held_val : direct_val) : arg_cur[i];
			end
		end
	end

	assign {arg_c_out, arg_b_out, arg_a_out} = arg_q;

endmodule

// ==== src/operand_fetch_stage.sv ====
module operand_fetch_stage #(
	parameter int data_width = 16
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input operand_fetch_pkg::opcode_t opcode,
	input operand_fetch_pkg::chan_idx_t dest,
	input logic writes_channel,
	input logic [data_width - 1:0] register_0, register_1,
	input operand_fetch_pkg::src_sel_u src_a, src_b, src_c,
	input logic src_a_imm, src_b_imm, src_c_imm,
	input logic arg_a_needed, arg_b_needed, arg_c_needed,
	output logic out_valid,
	input logic out_ready,
	output operand_fetch_pkg::opcode_t opcode_out,
	output operand_fetch_pkg::chan_idx_t dest_out,
	output logic writes_channel_out,
	output logic [data_width - 1:0] arg_a, arg_b, arg_c,
	input logic channel_write_enable,
	input operand_fetch_pkg::chan_idx_t channel_write_addr,
	input logic [data_width - 1:0] channel_write_val
);
	logic valid_ab, ready_ab, valid_bc, ready_bc;
	logic writes_ab, writes_bc;
	logic [2:0] imm_ab, imm_bc, need_ab, need_bc;
	operand_fetch_pkg::opcode_t opcode_ab, opcode_bc;
	operand_fetch_pkg::chan_idx_t dest_ab, dest_bc, addr_a, addr_b, addr_c;
	operand_fetch_pkg::src_sel_u src_a_ab, src_b_ab, src_c_ab, src_a_bc, src_b_bc, src_c_bc;
	logic [data_width - 1:0] r0_ab, r1_ab, r0_bc, r1_bc, val_a, val_b, val_c;
	logic [data_width - 1:0] arg_a_ab, arg_b_ab, arg_c_ab, arg_a_bc, arg_b_bc, arg_c_bc;

	channel_file #(.data_width(data_width)) channels (
		.clk(clk), .reset(reset), .channel_write_enable(channel_write_enable),
		.channel_write_addr(channel_write_addr), .channel_write_val(channel_write_val),
		.read_addr_a(addr_a), .read_addr_b(addr_b), .read_addr_c(addr_c),
		.read_val_a(val_a), .read_val_b(val_b), .read_val_c(val_c)
	);

	fetch_substage #(.data_width(data_width), .slot(0)) fetch_a (
		.clk(clk), .reset(reset), .in_valid(in_valid), .in_ready(in_ready),
		.out_valid(valid_ab), .out_ready(ready_ab), .read_addr(addr_a), .read_val(val_a),
		.opcode_in(opcode), .dest_in(dest), .writes_channel_in(writes_channel),
		.register_0_in(register_0), .register_1_in(register_1),
		.src_a_in(src_a), .src_b_in(src_b), .src_c_in(src_c),
		.src_a_imm_in(src_a_imm), .src_b_imm_in(src_b_imm), .src_c_imm_in(src_c_imm),
		.arg_a_needed_in(arg_a_needed), .arg_b_needed_in(arg_b_needed),
		.arg_c_needed_in(arg_c_needed), .arg_a_in('0), .arg_b_in('0), .arg_c_in('0),
		.channel_write_enable(channel_write_enable), .channel_write_addr(channel_write_addr),
		.channel_write_val(channel_write_val),
		.opcode_out(opcode_ab), .dest_out(dest_ab), .writes_channel_out(writes_ab),
		.register_0_out(r0_ab), .register_1_out(r1_ab),
		.src_a_out(src_a_ab), .src_b_out(src_b_ab), .src_c_out(src_c_ab),
		.src_a_imm_out(imm_ab[0]), .src_b_imm_out(imm_ab[1]), .src_c_imm_out(imm_ab[2]),
		.arg_a_needed_out(need_ab[0]), .arg_b_needed_out(need_ab[1]),
		.arg_c_needed_out(need_ab[2]),
		.arg_a_out(arg_a_ab), .arg_b_out(arg_b_ab), .arg_c_out(arg_c_ab)
	);

	fetch_substage #(.data_width(data_width), .slot(1)) fetch_b (
		.clk(clk), .reset(reset), .in_valid(valid_ab), .in_ready(ready_ab),
		.out_valid(valid_bc), .out_ready(ready_bc), .read_addr(addr_b), .read_val(val_b),
		.opcode_in(opcode_ab), .dest_in(dest_ab), .writes_channel_in(writes_ab),
		.register_0_in(r0_ab), .register_1_in(r1_ab),
		.src_a_in(src_a_ab), .src_b_in(src_b_ab), .src_c_in(src_c_ab),
		.src_a_imm_in(imm_ab[0]), .src_b_imm_in(imm_ab[1]), .src_c_imm_in(imm_ab[2]),
		.arg_a_needed_in(need_ab[0]), .arg_b_needed_in(need_ab[1]),
		.arg_c_needed_in(need_ab[2]),
		.arg_a_in(arg_a_ab), .arg_b_in(arg_b_ab), .arg_c_in(arg_c_ab),
		.channel_write_enable(channel_write_enable), .channel_write_addr(channel_write_addr),
		.channel_write_val(channel_write_val),
		.opcode_out(opcode_bc), .dest_out(dest_bc), .writes_channel_out(writes_bc),
		.register_0_out(r0_bc), .register_1_out(r1_bc),
		.src_a_out(src_a_bc), .src_b_out(src_b_bc), .src_c_out(src_c_bc),
		.src_a_imm_out(imm_bc[0]), .src_b_imm_out(imm_bc[1]), .src_c_imm_out(imm_bc[2]),
		.arg_a_needed_out(need_bc[0]), .arg_b_needed_out(need_bc[1]),
		.arg_c_needed_out(need_bc[2]),
		.arg_a_out(arg_a_bc), .arg_b_out(arg_b_bc), .arg_c_out(arg_c_bc)
	);

	// Last substage delivers only the opcode, dest, write flag and the three operands.
	fetch_substage #(.data_width(data_width), .slot(2)) fetch_c (
		.clk(clk), .reset(reset), .in_valid(valid_bc), .in_ready(ready_bc),
		.out_valid(out_valid), .out_ready(out_ready), .read_addr(addr_c), .read_val(val_c),
		.opcode_in(opcode_bc), .dest_in(dest_bc), .writes_channel_in(writes_bc),
		.register_0_in(r0_bc), .register_1_in(r1_bc),
		.src_a_in(src_a_bc), .src_b_in(src_b_bc), .src_c_in(src_c_bc),
		.src_a_imm_in(imm_bc[0]), .src_b_imm_in(imm_bc[1]), .src_c_imm_in(imm_bc[2]),
		.arg_a_needed_in(need_bc[0]), .arg_b_needed_in(need_bc[1]),
		.arg_c_needed_in(need_bc[2]),
		.arg_a_in(arg_a_bc), .arg_b_in(arg_b_bc), .arg_c_in(arg_c_bc),
		.channel_write_enable(channel_write_enable), .channel_write_addr(channel_write_addr),
		.channel_write_val(channel_write_val),
		.opcode_out(opcode_out), .dest_out(dest_out), .writes_channel_out(writes_channel_out),
		.register_0_out(), .register_1_out(),
		.src_a_out(), .src_b_out(), .src_c_out(),
		.src_a_imm_out(), .src_b_imm_out(), .src_c_imm_out(),
		.arg_a_needed_out(), .arg_b_needed_out(), .arg_c_needed_out(),
		.arg_a_out(arg_a), .arg_b_out(arg_b), .arg_c_out(arg_c)
	);

endmodule

// ==== testbench/operand_fetch_tb.sv ====
module operand_fetch_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int data_width = 16;
	localparam int num_instr = 400;
	localparam int wait_limit = 2000;
	localparam int max_writers = 8;

	logic clk, reset, in_valid, in_ready, out_valid, out_ready;
	operand_fetch_pkg::opcode_t opcode, opcode_out;
	operand_fetch_pkg::chan_idx_t dest, dest_out, channel_write_addr;
	logic writes_channel, writes_channel_out, channel_write_enable;
	logic [data_width - 1:0] register_0, register_1, channel_write_val;
	logic [data_width - 1:0] arg_a, arg_b, arg_c;
	operand_fetch_pkg::src_sel_u src_a, src_b, src_c;
	logic src_a_imm, src_b_imm, src_c_imm, arg_a_needed, arg_b_needed, arg_c_needed;

	logic [31:0] lfsr_state = 32'hed8e_e660;
	logic [data_width - 1:0] model_channels [16];
	// Expected results in issue order.
	logic [2:0][data_width - 1:0] exp_args_q [$];
	logic [data_width - 1:0] exp_wb_val_q [$];
	operand_fetch_pkg::opcode_t exp_opcode_q [$];
	operand_fetch_pkg::chan_idx_t exp_dest_q [$];
	logic exp_writes_q [$];
	// Writers that left the DUT and wait for their writeback.
	operand_fetch_pkg::chan_idx_t wb_addr_q [$];
	logic [data_width - 1:0] wb_val_q [$];
	int writers_outstanding = 0;
	int outputs_seen = 0;
	int mismatch_count = 0;
	int failure_count = 0;

	operand_fetch_stage #(.data_width(data_width)) dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		logic feedback;
		value = '0;
		for (int i = 0; i < n; i++) begin
			feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	// Low channels come up more often, so hazards are frequent.
	function automatic logic [3:0] pick_channel();
		return rand_bits(1) != 0 ? 4'(rand_bits(2)) : 4'(rand_bits(4));
	endfunction

	function automatic logic [data_width - 1:0] expected_operand(input logic needed,
		input logic imm, input logic [3:0] sel, input logic [data_width - 1:0] r0,
		input logic [data_width - 1:0] r1);
		logic [data_width - 1:0] value;
		value = '0;
		if (needed && !imm) begin
			value = model_channels[sel];
		end else if (needed) begin
			case (sel)
				4'd0: value = r0;
				4'd1: value = r1;
				4'd3: value[data_width - 2] = 1'b1;
				4'd4: value[data_width - 1] = 1'b1;
				default: value = '0;
			endcase
		end
		return value;
	endfunction

	task automatic finish_run();
		$display("Errors: %0d mismatches, %0d other failures, %0d of %0d instructions checked",
			mismatch_count, failure_count, outputs_seen, num_instr);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		failure_count++;
		$display("Timeout at %0d ns: %s", $time, what);
		finish_run();
	endtask

	task automatic check_field(input string name, input logic [data_width - 1:0] got,
		input logic [data_width - 1:0] expected);
		assert (got === expected) else begin
			mismatch_count++;
			$display("Mismatch at %0d ns: %s = %h, expected %h", $time, name, got, expected);
		end
	endtask

	task automatic drive_instruction();
		logic [2:0] needed, imm;
		logic [2:0][3:0] sel;
		logic [2:0][data_width - 1:0] args;
		logic [data_width - 1:0] r0, r1, wb_val;
		operand_fetch_pkg::opcode_t opc;
		operand_fetch_pkg::chan_idx_t dst;
		logic writes;
		for (int k = 0; k < 3; k++) begin
			needed[k] = rand_bits(3) != 0;
			imm[k] = rand_bits(1) != 0;
			sel[k] = imm[k] ? 4'(rand_bits(3)) : pick_channel();
		end
		r0 = data_width'(rand_bits(data_width));
		r1 = data_width'(rand_bits(data_width));
		wb_val = data_width'(rand_bits(data_width));
		opc = operand_fetch_pkg::opcode_t'(rand_bits(5));
		dst = pick_channel();
		writes = rand_bits(2) != 0;
		for (int k = 0; k < 3; k++) begin
			args[k] = expected_operand(needed[k], imm[k], sel[k], r0, r1);
		end
		// The write is seen only by younger instructions.
		if (writes) begin
			model_channels[dst] = wb_val;
			writers_outstanding++;
		end
		exp_args_q.push_back(args);
		exp_wb_val_q.push_back(wb_val);
		exp_opcode_q.push_back(opc);
		exp_dest_q.push_back(dst);
		exp_writes_q.push_back(writes);
		in_valid <= 1'b1;
		opcode <= opc;
		dest <= dst;
		writes_channel <= writes;
		register_0 <= r0;
		register_1 <= r1;
		src_a <= sel[0];
		src_b <= sel[1];
		src_c <= sel[2];
		{src_c_imm, src_b_imm, src_a_imm} <= imm;
		{arg_c_needed, arg_b_needed, arg_a_needed} <= needed;
	endtask

	task automatic wait_for_accept();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!in_ready && cycles <= wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (cycles > wait_limit) report_timeout("the DUT never accepted an instruction");
	endtask

	task automatic issue_all();
		int cycles;
		logic gap;
		@(posedge clk);
		for (int n = 0; n < num_instr; n++) begin
			drive_instruction();
			wait_for_accept();
			gap = rand_bits(2) == 0 || writers_outstanding >= max_writers;
			// Transfer edge of the instruction just accepted.
			@(posedge clk);
			if (gap) begin
				in_valid <= 1'b0;
				cycles = 0;
				@(negedge clk);
				while (writers_outstanding >= max_writers && cycles <= wait_limit) begin
					@(negedge clk);
					cycles++;
				end
				if (cycles > wait_limit) report_timeout("writebacks stopped coming back");
				@(posedge clk);
			end
		end
		in_valid <= 1'b0;
	endtask

	initial begin : drive_out_ready
		forever begin
			@(posedge clk);
			out_ready <= rand_bits(2) != 0;
		end
	end

	// One emerged writer per write, in output order.
	initial begin : drive_writeback
		int delay;
		delay = 0;
		forever begin
			@(posedge clk);
			channel_write_enable <= 1'b0;
			if (delay > 0) begin
				delay--;
			end else if (wb_addr_q.size() > 0) begin
				channel_write_enable <= 1'b1;
				channel_write_addr <= wb_addr_q.pop_front();
				channel_write_val <= wb_val_q.pop_front();
				writers_outstanding--;
				delay = int'(rand_bits(2));
			end
		end
	end

	initial begin : compare_outputs
		logic [2:0][data_width - 1:0] args;
		logic [data_width - 1:0] wb_val;
		operand_fetch_pkg::chan_idx_t dst;
		logic writes;
		forever begin
			@(negedge clk);
			if (!reset && out_valid && out_ready) begin
				assert (exp_args_q.size() > 0) else begin
					failure_count++;
					$display("Output at %0d ns with no instruction outstanding", $time);
				end
				if (exp_args_q.size() > 0) begin
					args = exp_args_q.pop_front();
					wb_val = exp_wb_val_q.pop_front();
					dst = exp_dest_q.pop_front();
					writes = exp_writes_q.pop_front();
					check_field("opcode_out", data_width'(opcode_out),
						data_width'(exp_opcode_q.pop_front()));
					check_field("dest_out", data_width'(dest_out), data_width'(dst));
					check_field("writes_channel_out", data_width'(writes_channel_out),
						data_width'(writes));
					check_field("arg_a", arg_a, args[0]);
					check_field("arg_b", arg_b, args[1]);
					check_field("arg_c", arg_c, args[2]);
					if (writes) begin
						wb_addr_q.push_back(dst);
						wb_val_q.push_back(wb_val);
					end
					outputs_seen++;
				end
			end
		end
	end

	initial begin : run_test
		int cycles;
		reset = 1'b1;
		in_valid = 1'b0;
		opcode = '0;
		dest = '0;
		writes_channel = 1'b0;
		register_0 = '0;
		register_1 = '0;
		src_a = '0;
		src_b = '0;
		src_c = '0;
		{src_a_imm, src_b_imm, src_c_imm} = '0;
		{arg_a_needed, arg_b_needed, arg_c_needed} = '0;
		out_ready = 1'b0;
		channel_write_enable = 1'b0;
		channel_write_addr = '0;
		channel_write_val = '0;
		for (int i = 0; i < 16; i++) begin
			model_channels[i] = '0;
		end
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert (!out_valid && in_ready) else begin
			failure_count++;
			$display("After reset out_valid is %b and in_ready is %b", out_valid, in_ready);
		end
		issue_all();
		cycles = 0;
		while ((outputs_seen < num_instr || wb_addr_q.size() > 0) && cycles <= wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (cycles > wait_limit) begin
			report_timeout("not every instruction came out of the DUT");
		end else begin
			assert (exp_args_q.size() == 0 && outputs_seen == num_instr) else begin
				failure_count++;
				$display("%0d outputs for %0d instructions", outputs_seen, num_instr);
			end
			finish_run();
		end
	end

endmodule

// ==== operand_fetch.f ====
src/operand_fetch_pkg.sv
src/channel_file.sv
src/pending_write_counter.sv
src/fetch_control.sv
src/operand_select.sv
src/fetch_substage.sv
src/operand_fetch_stage.sv
testbench/operand_fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module operand_fetch_tb \
	-f operand_fetch.f -o operand_fetch_sim
./obj_dir/operand_fetch_sim | tee sim.log

if grep -q "^Test completed successfully$" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
